/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tlb.f --top-module tb_tlb_unit

out=$(./obj_dir/Vtb_tlb_unit)
echo "$out"

# exit status of grep decides pass or fail
echo "$out" | grep -q "^Test OK$"

/* src/tlb_entry_array.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tlb_settings.svh"

module tlb_entry_array (
    input  wire                     clk,
    input  wire                     arst_n,
    // write port
    input  wire                     we,
    input  wire tlb_pkg::idx_t      w_index,
    input  wire                     w_e,
    input  wire tlb_pkg::ps_t       w_ps,
    input  wire tlb_pkg::vppn_t     w_vppn,
    input  wire tlb_pkg::asid_t     w_asid,
    input  wire                     w_g,
    input  wire tlb_pkg::ppn_t      w_ppn0,
    input  wire tlb_pkg::plv_t      w_plv0,
    input  wire tlb_pkg::mat_t      w_mat0,
    input  wire                     w_d0,
    input  wire                     w_v0,
    input  wire tlb_pkg::ppn_t      w_ppn1,
    input  wire tlb_pkg::plv_t      w_plv1,
    input  wire tlb_pkg::mat_t      w_mat1,
    input  wire                     w_d1,
    input  wire                     w_v1,
    // invalidate, hit vectors come from the s1 lookup
    input  wire                     invtlb_valid,
    input  wire tlb_pkg::invop_t    invtlb_op,
    input  wire tlb_pkg::hitvec_t   va_hit,
    input  wire tlb_pkg::hitvec_t   asid_hit,
    // read port
    input  wire tlb_pkg::idx_t      r_index,
    output logic                    r_e,
    output tlb_pkg::ps_t            r_ps,
    output tlb_pkg::vppn_t          r_vppn,
    output tlb_pkg::asid_t          r_asid,
    output logic                    r_g,
    output tlb_pkg::ppn_t           r_ppn0,
    output tlb_pkg::plv_t           r_plv0,
    output tlb_pkg::mat_t           r_mat0,
    output logic                    r_d0,
    output logic                    r_v0,
    output tlb_pkg::ppn_t           r_ppn1,
    output tlb_pkg::plv_t           r_plv1,
    output tlb_pkg::mat_t           r_mat1,
    output logic                    r_d1,
    output logic                    r_v1,
    tlb_table_if.store              tbl
);

    tlb_pkg::hitvec_t inv_sel;

    // entries named by the invtlb op
    always_comb begin
        case (invtlb_op)
            5'd0, 5'd1: inv_sel = '1;
            5'd2:       inv_sel = tbl.g;
            5'd3:       inv_sel = ~tbl.g;
            5'd4:       inv_sel = ~tbl.g & asid_hit;
            5'd5:       inv_sel = ~tbl.g & asid_hit & va_hit;
            5'd6:       inv_sel = (tbl.g | asid_hit) & va_hit;
            default:    inv_sel = '0;
        endcase
    end

    // write has priority over invalidate on the same entry
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tbl.e <= '0;
        end else begin
            for (int i = 0; i < `TLB_NUM; i++) begin
                if (we && w_index == tlb_pkg::idx_t'(i)) begin
                    tbl.e[i] <= w_e;
                end else if (invtlb_valid && inv_sel[i]) begin
                    tbl.e[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            tbl.vppn[w_index] <= w_vppn;
            tbl.ps[w_index]   <= w_ps;
            tbl.asid[w_index] <= w_asid;
            tbl.g[w_index]    <= w_g;
            tbl.ppn0[w_index] <= w_ppn0;
            tbl.plv0[w_index] <= w_plv0;
            tbl.mat0[w_index] <= w_mat0;
            tbl.d0[w_index]   <= w_d0;
            tbl.v0[w_index]   <= w_v0;
            tbl.ppn1[w_index] <= w_ppn1;
            tbl.plv1[w_index] <= w_plv1;
            tbl.mat1[w_index] <= w_mat1;
            tbl.d1[w_index]   <= w_d1;
            tbl.v1[w_index]   <= w_v1;
        end
    end

    assign r_e    = tbl.e[r_index];
    assign r_ps   = tbl.ps[r_index];
    assign r_vppn = tbl.vppn[r_index];
    assign r_asid = tbl.asid[r_index];
    assign r_g    = tbl.g[r_index];
    assign r_ppn0 = tbl.ppn0[r_index];
    assign r_plv0 = tbl.plv0[r_index];
    assign r_mat0 = tbl.mat0[r_index];
    assign r_d0   = tbl.d0[r_index];
    assign r_v0   = tbl.v0[r_index];
    assign r_ppn1 = tbl.ppn1[r_index];
    assign r_plv1 = tbl.plv1[r_index];
    assign r_mat1 = tbl.mat1[r_index];
    assign r_d1   = tbl.d1[r_index];
    assign r_v1   = tbl.v1[r_index];

endmodule

`default_nettype wire

/* src/tlb_lookup.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tlb_settings.svh"

module tlb_lookup (
    input  wire tlb_pkg::vppn_t     vppn,
    input  wire                     va_bit12,
    input  wire tlb_pkg::asid_t     asid,
    tlb_table_if.search             tbl,
    output logic                    found,
    output tlb_pkg::idx_t           index,
    output tlb_pkg::ppn_t           ppn,
    output tlb_pkg::ps_t            ps,
    output tlb_pkg::plv_t           plv,
    output tlb_pkg::mat_t           mat,
    output logic                    d,
    output logic                    v,
    output tlb_pkg::hitvec_t        va_hit,
    output tlb_pkg::hitvec_t        asid_hit
);

    tlb_pkg::hitvec_t hit;
    logic             odd;

    // parallel compare against every entry
    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            asid_hit[i] = (tbl.asid[i] == asid);
            if (tbl.ps[i] == `TLB_PS_4K) begin
                va_hit[i] = (tbl.vppn[i] == vppn);
            end else begin
                // 2M page, low vppn bits are offset
                va_hit[i] = (tbl.vppn[i][18:9] == vppn[18:9]);
            end
            hit[i] = tbl.e[i] && va_hit[i] && (tbl.g[i] || asid_hit[i]);
        end
    end

    // lowest hitting entry wins
    always_comb begin
        index = '0;
        for (int i = `TLB_NUM - 1; i >= 0; i--) begin
            if (hit[i]) begin
                index = tlb_pkg::idx_t'(i);
            end
        end
    end

    assign found = |hit;

    // page half select depends on the entry's page size
    assign odd = (tbl.ps[index] == `TLB_PS_2M) ? vppn[8] : va_bit12;

    always_comb begin
        if (!found) begin
            ps  = '0;
            ppn = '0;
            plv = '0;
            mat = '0;
            d   = 1'b0;
            v   = 1'b0;
        end else if (odd) begin
            ps  = tbl.ps[index];
            ppn = tbl.ppn1[index];
            plv = tbl.plv1[index];
            mat = tbl.mat1[index];
            d   = tbl.d1[index];
            v   = tbl.v1[index];
        end else begin
            ps  = tbl.ps[index];
            ppn = tbl.ppn0[index];
            plv = tbl.plv0[index];
            mat = tbl.mat0[index];
            d   = tbl.d0[index];
            v   = tbl.v0[index];
        end
    end

endmodule

`default_nettype wire

/* src/tlb_pkg.sv */
`default_nettype none

`include "tlb_settings.svh"

package tlb_pkg;

    // va bits 31 to 13, one pair of pages
    typedef logic [18:0] vppn_t;
    typedef logic [9:0]  asid_t;
    typedef logic [19:0] ppn_t;
    typedef logic [5:0]  ps_t;
    typedef logic [1:0]  plv_t;
    typedef logic [1:0]  mat_t;

    typedef logic [`TLB_IDX_W-1:0] idx_t;

    // invtlb op field
    typedef logic [4:0] invop_t;

    // one bit per entry
    typedef logic [`TLB_NUM-1:0] hitvec_t;

endpackage

`default_nettype wire

/* src/tlb_settings.svh */
`ifndef TLB_SETTINGS_SVH
`define TLB_SETTINGS_SVH

// number of entries, power of two
`define TLB_NUM 16

// log2 of TLB_NUM
`define TLB_IDX_W 4

// page size codes
`define TLB_PS_4K 6'd12
`define TLB_PS_2M 6'd21

`endif

/* src/tlb_table_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tlb_settings.svh"

interface tlb_table_if;

    // per-entry flags, packed so they combine bitwise
    tlb_pkg::hitvec_t e;
    tlb_pkg::hitvec_t g;

    tlb_pkg::vppn_t   vppn [`TLB_NUM];
    tlb_pkg::ps_t     ps   [`TLB_NUM];
    tlb_pkg::asid_t   asid [`TLB_NUM];

    // even page
    tlb_pkg::ppn_t    ppn0 [`TLB_NUM];
    tlb_pkg::plv_t    plv0 [`TLB_NUM];
    tlb_pkg::mat_t    mat0 [`TLB_NUM];
    tlb_pkg::hitvec_t d0;
    tlb_pkg::hitvec_t v0;

    // odd page
    tlb_pkg::ppn_t    ppn1 [`TLB_NUM];
    tlb_pkg::plv_t    plv1 [`TLB_NUM];
    tlb_pkg::mat_t    mat1 [`TLB_NUM];
    tlb_pkg::hitvec_t d1;
    tlb_pkg::hitvec_t v1;

    modport store (
        output e, g, vppn, ps, asid,
        output ppn0, plv0, mat0, d0, v0,
        output ppn1, plv1, mat1, d1, v1
    );

    modport search (
        input e, g, vppn, ps, asid,
        input ppn0, plv0, mat0, d0, v0,
        input ppn1, plv1, mat1, d1, v1
    );

endinterface

`default_nettype wire

/* src/tlb_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module tlb_unit (
    input  wire                     clk,
    input  wire                     arst_n,
    // search port 0, fetch
    input  wire tlb_pkg::vppn_t     s0_vppn,
    input  wire                     s0_va_bit12,
    input  wire tlb_pkg::asid_t     s0_asid,
    output wire                     s0_found,
    output wire tlb_pkg::idx_t      s0_index,
    output wire tlb_pkg::ppn_t      s0_ppn,
    output wire tlb_pkg::ps_t       s0_ps,
    output wire tlb_pkg::plv_t      s0_plv,
    output wire tlb_pkg::mat_t      s0_mat,
    output wire                     s0_d,
    output wire                     s0_v,
    // search port 1, load/store and invtlb
    input  wire tlb_pkg::vppn_t     s1_vppn,
    input  wire                     s1_va_bit12,
    input  wire tlb_pkg::asid_t     s1_asid,
    output wire                     s1_found,
    output wire tlb_pkg::idx_t      s1_index,
    output wire tlb_pkg::ppn_t      s1_ppn,
    output wire tlb_pkg::ps_t       s1_ps,
    output wire tlb_pkg::plv_t      s1_plv,
    output wire tlb_pkg::mat_t      s1_mat,
    output wire                     s1_d,
    output wire                     s1_v,
    input  wire                     invtlb_valid,
    input  wire tlb_pkg::invop_t    invtlb_op,
    // write port
    input  wire                     we,
    input  wire tlb_pkg::idx_t      w_index,
    input  wire                     w_e,
    input  wire tlb_pkg::ps_t       w_ps,
    input  wire tlb_pkg::vppn_t     w_vppn,
    input  wire tlb_pkg::asid_t     w_asid,
    input  wire                     w_g,
    input  wire tlb_pkg::ppn_t      w_ppn0,
    input  wire tlb_pkg::plv_t      w_plv0,
    input  wire tlb_pkg::mat_t      w_mat0,
    input  wire                     w_d0,
    input  wire                     w_v0,
    input  wire tlb_pkg::ppn_t      w_ppn1,
    input  wire tlb_pkg::plv_t      w_plv1,
    input  wire tlb_pkg::mat_t      w_mat1,
    input  wire                     w_d1,
    input  wire                     w_v1,
    // read port
    input  wire tlb_pkg::idx_t      r_index,
    output wire                     r_e,
    output wire tlb_pkg::ps_t       r_ps,
    output wire tlb_pkg::vppn_t     r_vppn,
    output wire tlb_pkg::asid_t     r_asid,
    output wire                     r_g,
    output wire tlb_pkg::ppn_t      r_ppn0,
    output wire tlb_pkg::plv_t      r_plv0,
    output wire tlb_pkg::mat_t      r_mat0,
    output wire                     r_d0,
    output wire                     r_v0,
    output wire tlb_pkg::ppn_t      r_ppn1,
    output wire tlb_pkg::plv_t      r_plv1,
    output wire tlb_pkg::mat_t      r_mat1,
    output wire                     r_d1,
    output wire                     r_v1
);

    tlb_pkg::hitvec_t s1_va_hit;
    tlb_pkg::hitvec_t s1_asid_hit;

    tlb_table_if u_table ();

    // port names match the top level, except the table and hit vectors
    tlb_entry_array u_array (
        .tbl      (u_table.store),
        .va_hit   (s1_va_hit),
        .asid_hit (s1_asid_hit),
        .*
    );

    tlb_lookup u_lookup_s0 (
        .vppn     (s0_vppn),
        .va_bit12 (s0_va_bit12),
        .asid     (s0_asid),
        .tbl      (u_table.search),
        .found    (s0_found),
        .index    (s0_index),
        .ppn      (s0_ppn),
        .ps       (s0_ps),
        .plv      (s0_plv),
        .mat      (s0_mat),
        .d        (s0_d),
        .v        (s0_v),
        .va_hit   (),
        .asid_hit ()
    );

    tlb_lookup u_lookup_s1 (
        .vppn     (s1_vppn),
        .va_bit12 (s1_va_bit12),
        .asid     (s1_asid),
        .tbl      (u_table.search),
        .found    (s1_found),
        .index    (s1_index),
        .ppn      (s1_ppn),
        .ps       (s1_ps),
        .plv      (s1_plv),
        .mat      (s1_mat),
        .d        (s1_d),
        .v        (s1_v),
        .va_hit   (s1_va_hit),
        .asid_hit (s1_asid_hit)
    );

endmodule

`default_nettype wire

/* tests/tb_tlb_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tlb_settings.svh"

module tb_tlb_unit;

    typedef struct packed {
        logic e;
        tlb_pkg::ps_t ps;
        tlb_pkg::vppn_t vppn;
        tlb_pkg::asid_t asid;
        logic g;
        tlb_pkg::ppn_t ppn0;
        tlb_pkg::plv_t plv0;
        tlb_pkg::mat_t mat0;
        logic d0;
        logic v0;
        tlb_pkg::ppn_t ppn1;
        tlb_pkg::plv_t plv1;
        tlb_pkg::mat_t mat1;
        logic d1;
        logic v1;
    } entry_t;

    logic clk, arst_n, we, invtlb_valid;
    logic s0_va_bit12, s1_va_bit12, s0_found, s1_found, s0_d, s1_d, s0_v, s1_v;
    tlb_pkg::vppn_t s0_vppn, s1_vppn, r_vppn;
    tlb_pkg::asid_t s0_asid, s1_asid, r_asid;
    tlb_pkg::idx_t s0_index, s1_index, w_index, r_index;
    tlb_pkg::ppn_t s0_ppn, s1_ppn, r_ppn0, r_ppn1;
    tlb_pkg::ps_t s0_ps, s1_ps, r_ps;
    tlb_pkg::plv_t s0_plv, s1_plv, r_plv0, r_plv1;
    tlb_pkg::mat_t s0_mat, s1_mat, r_mat0, r_mat1;
    tlb_pkg::invop_t invtlb_op;
    logic r_e, r_g, r_d0, r_v0, r_d1, r_v1;
    entry_t w_ent, r_ent;

    // shadow table
    entry_t m_tbl [`TLB_NUM];
    logic m_written [`TLB_NUM];
    int errors;
    logic [31:0] rng_state;

    tlb_unit uut (
        .w_e (w_ent.e), .w_ps (w_ent.ps), .w_vppn (w_ent.vppn),
        .w_asid (w_ent.asid), .w_g (w_ent.g),
        .w_ppn0 (w_ent.ppn0), .w_plv0 (w_ent.plv0), .w_mat0 (w_ent.mat0),
        .w_d0 (w_ent.d0), .w_v0 (w_ent.v0),
        .w_ppn1 (w_ent.ppn1), .w_plv1 (w_ent.plv1), .w_mat1 (w_ent.mat1),
        .w_d1 (w_ent.d1), .w_v1 (w_ent.v1),
        .*
    );

    assign r_ent = {r_e, r_ps, r_vppn, r_asid, r_g, r_ppn0, r_plv0, r_mat0, r_d0, r_v0,
                    r_ppn1, r_plv1, r_mat1, r_d1, r_v1};

    always #50 clk = ~clk;

    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        #10 arst_n = 1'b1;
    end

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // 4K pages compare the whole vppn and 2M pages only bits 18 to 9
    function automatic logic va_match(entry_t ent, tlb_pkg::vppn_t vppn);
        if (ent.ps == `TLB_PS_2M) return ent.vppn[18:9] == vppn[18:9];
        return ent.vppn == vppn;
    endfunction

    function automatic logic inv_match(tlb_pkg::invop_t op, entry_t ent,
                                       tlb_pkg::vppn_t vppn, tlb_pkg::asid_t asid);
        logic ah;
        logic vh;
        ah = (ent.asid == asid);
        vh = va_match(ent, vppn);
        case (op)
            5'd0, 5'd1: return 1'b1;
            5'd2: return ent.g;
            5'd3: return !ent.g;
            5'd4: return !ent.g && ah;
            5'd5: return !ent.g && ah && vh;
            5'd6: return (ent.g || ah) && vh;
            default: return 1'b0;
        endcase
    endfunction

    // small vppn pool so that searches hit often
    function automatic entry_t make_entry(logic [31:0] r0, logic [31:0] r1, logic big);
        entry_t ent;
        ent = {1'b1, big ? `TLB_PS_2M : `TLB_PS_4K,
               {8'h35, r0[21:20], r0[22], 7'h0, r0[23]}, {8'h0, r0[17:16]},
               r0[18] & r0[19], r1[19:0], r0[5:4], r0[7:6], r0[8], r0[9],
               {r1[11:0], r0[31:24]}, r0[11:10], r0[13:12], r0[14], r0[15]};
        return ent;
    endfunction

    task automatic check_val(input string name, input logic [95:0] exp,
                             input logic [95:0] act);
        assert (act === exp) else begin
            errors++;
            $display("error at %0t: %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    task automatic check_port(input string pfx, input tlb_pkg::vppn_t vppn,
                              input logic b12, input tlb_pkg::asid_t asid,
                              input logic found, input tlb_pkg::idx_t index,
                              input logic [31:0] pg);
        logic exp_found;
        tlb_pkg::idx_t exp_idx;
        logic [31:0] exp_pg;
        entry_t ent;
        exp_found = 1'b0;
        exp_idx = '0;
        exp_pg = '0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            ent = m_tbl[i];
            if (!exp_found && ent.e && va_match(ent, vppn) && (ent.g || ent.asid == asid)) begin
                exp_found = 1'b1;
                exp_idx = tlb_pkg::idx_t'(i);
            end
        end
        if (exp_found) begin
            ent = m_tbl[exp_idx];
            // 2M pages pick the half by vppn bit 8 and 4K pages by va bit 12
            if ((ent.ps == `TLB_PS_2M) ? vppn[8] : b12)
                exp_pg = {ent.ps, ent.ppn1, ent.plv1, ent.mat1, ent.d1, ent.v1};
            else
                exp_pg = {ent.ps, ent.ppn0, ent.plv0, ent.mat0, ent.d0, ent.v0};
            check_val({pfx, "_index"}, 96'(exp_idx), 96'(index));
        end
        check_val({pfx, "_found"}, 96'(exp_found), 96'(found));
        check_val({pfx, "_ps/ppn/plv/mat/d/v"}, 96'(exp_pg), 96'(pg));
    endtask

    // check just before the edge and then step the model with that edge
    task automatic run_cycle();
        #80;
        check_port("s0", s0_vppn, s0_va_bit12, s0_asid, s0_found, s0_index,
                   {s0_ps, s0_ppn, s0_plv, s0_mat, s0_d, s0_v});
        check_port("s1", s1_vppn, s1_va_bit12, s1_asid, s1_found, s1_index,
                   {s1_ps, s1_ppn, s1_plv, s1_mat, s1_d, s1_v});
        check_val("r_e", 96'(m_tbl[r_index].e), 96'(r_e));
        if (m_written[r_index]) check_val("r_entry", 96'(m_tbl[r_index]), 96'(r_ent));
        for (int i = 0; i < `TLB_NUM; i++) begin
            if (we && w_index == tlb_pkg::idx_t'(i)) begin
                m_tbl[i] = w_ent;
                m_written[i] = 1'b1;
            end else if (invtlb_valid && inv_match(invtlb_op, m_tbl[i], s1_vppn, s1_asid)) begin
                m_tbl[i].e = 1'b0;
            end
        end
        @(posedge clk);
        #10;
    endtask

    // async reset while entries are valid clears only the e bits
    task automatic pulse_reset();
        arst_n = 1'b0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            m_tbl[i].e = 1'b0;
        end
        run_cycle();
        arst_n = 1'b1;
    endtask

    task automatic write_entry(input int idx, input entry_t ent);
        we = 1'b1;
        w_index = tlb_pkg::idx_t'(idx);
        w_ent = ent;
        run_cycle();
        we = 1'b0;
    endtask

    // s1 looks at the other page half
    task automatic search_both(input tlb_pkg::vppn_t vppn, input logic b12,
                               input tlb_pkg::asid_t asid);
        s0_vppn = vppn;
        s0_va_bit12 = b12;
        s0_asid = asid;
        s1_vppn = vppn;
        s1_va_bit12 = !b12;
        s1_asid = asid;
        run_cycle();
    endtask

    task automatic read_all();
        for (int i = 0; i < `TLB_NUM; i++) begin
            r_index = tlb_pkg::idx_t'(i);
            run_cycle();
        end
    endtask

    task automatic run_directed();
        entry_t ea;
        entry_t eb;
        entry_t ec;
        repeat (4) begin
            ea = make_entry(xorshift(), xorshift(), 1'b0);
            search_both(ea.vppn, ea.ppn0[0], ea.asid);
        end
        read_all();
        ea = make_entry(xorshift(), xorshift(), 1'b0);
        ea.vppn = 19'h12345;
        ea.asid = 10'd5;
        ea.g = 1'b0;
        write_entry(3, ea);
        eb = make_entry(xorshift(), xorshift(), 1'b1);
        eb.vppn = 19'h54321;
        eb.g = 1'b1;
        write_entry(7, eb);
        // global duplicate of entry 3 at a higher index
        ec = make_entry(xorshift(), xorshift(), 1'b0);
        ec.vppn = ea.vppn;
        ec.g = 1'b1;
        write_entry(9, ec);
        for (int b = 0; b < 2; b++) begin
            search_both(ea.vppn, b[0], 10'd5);
            search_both(ea.vppn, b[0], 10'd6);
            search_both({eb.vppn[18:9], b[0], 8'h77}, 1'b0, 10'd9);
            search_both(ea.vppn ^ 19'h1, b[0], 10'd5);
        end
        read_all();
        pulse_reset();
        search_both(ea.vppn, 1'b0, 10'd5);
        read_all();
    endtask

    task automatic run_invalidate();
        entry_t ent;
        for (int op = 0; op < 8; op++) begin
            // every mix of g, asid match and va match
            for (int i = 0; i < 8; i++) begin
                ent = make_entry(xorshift(), xorshift(), 1'b0);
                ent.vppn = i[2] ? 19'h12345 : 19'h0abcd;
                ent.asid = i[1] ? 10'd5 : 10'd6;
                ent.g = i[0];
                write_entry(i, ent);
            end
            s1_vppn = 19'h12345;
            s1_asid = 10'd5;
            invtlb_valid = 1'b1;
            invtlb_op = tlb_pkg::invop_t'(op);
            run_cycle();
            invtlb_valid = 1'b0;
            read_all();
            search_both(19'h12345, 1'b0, 10'd5);
            search_both(19'h0abcd, 1'b1, 10'd6);
        end
    endtask

    task automatic run_random();
        logic [31:0] r;
        entry_t ent;
        repeat (300) begin
            r = xorshift();
            we = (r[1:0] == 2'd0);
            w_index = r[7:4];
            w_ent = make_entry(xorshift(), xorshift(), r[8]);
            w_ent.e = r[9] | r[10];
            invtlb_valid = (r[12:11] == 2'd0);
            invtlb_op = {2'b0, r[15:13]};
            r_index = r[19:16];
            ent = make_entry(xorshift(), xorshift(), 1'b0);
            s0_vppn = ent.vppn;
            s0_asid = ent.asid;
            s0_va_bit12 = r[20];
            ent = make_entry(xorshift(), xorshift(), 1'b0);
            s1_vppn = ent.vppn;
            s1_asid = ent.asid;
            s1_va_bit12 = r[21];
            run_cycle();
        end
        we = 1'b0;
        invtlb_valid = 1'b0;
    endtask

    initial begin
        int n;
        clk = 1'b0;
        errors = 0;
        rng_state = 32'd12;
        we = 1'b0;
        invtlb_valid = 1'b0;
        invtlb_op = '0;
        w_index = '0;
        w_ent = '0;
        r_index = '0;
        s0_vppn = '0;
        s0_va_bit12 = 1'b0;
        s0_asid = '0;
        s1_vppn = '0;
        s1_va_bit12 = 1'b0;
        s1_asid = '0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            m_tbl[i] = '0;
            m_written[i] = 1'b0;
        end
        n = 0;
        while (arst_n !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (arst_n !== 1'b1) begin
            errors++;
            $display("reset was not released within 20 cycles");
        end else begin
            #10;
            run_directed();
            run_invalidate();
            run_random();
        end
        $display("checks done, %0d errors", errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tlb.f */
+incdir+src
src/tlb_pkg.sv
src/tlb_table_if.sv
src/tlb_entry_array.sv
src/tlb_lookup.sv
src/tlb_unit.sv
tests/tb_tlb_unit.sv
